//--- logic/dcache_ctrl.sv
// One request at a time; memory must not return read data in the same cycle as mem_ack
`default_nettype none
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
    (
        input  logic        clk,
        input  logic        rst,
        input  logic        cache_on,
        input  logic        req,
        input  logic        load,
        input  logic        store,
        input  logic [31:0] addr,
        input  logic [3:0]  be,
        input  logic [31:0] wdata,
        output logic        ready,
        output logic        rvalid,
        output logic [31:0] rdata,
        output logic        mem_req,
        input  logic        mem_ack,
        output logic [31:0] mem_addr,
        output logic        mem_rnw,
        output logic [3:0]  mem_be,
        output logic [31:0] mem_wdata,
        output logic [2:0]  mem_burst_len,
        input  logic [31:0] mem_rdata,
        input  logic        hit,
        input  logic        hit_way,
        input  logic        victim_way,
        output logic        tag_update,
        input  logic [31:0] bank_word,
        output logic        lookup_en,
        output logic        lookup_way,
        output logic [3:0]  lookup_be,
        output logic        fill_en,
        output logic        fill_way,
        output logic [31:0] req_addr,
        output logic [31:0] req_wdata,
        output logic        burst_start,
        fill_if.ctrl        fill
    );

    dcache_state_t state;
    dcache_state_t state_next;

    logic        req_load;
    logic        req_store;
    logic [3:0]  req_be;
    logic        req_cached;
    logic        load_hit;
    logic        from_bank;
    logic [31:0] miss_word;

    ////////////////////
    // Stage two request
    always_ff @(posedge clk) begin
        if (req && ready) begin
            req_addr <= addr;
            req_wdata <= wdata;
            req_be <= be;
            req_load <= load;
            req_store <= store;
            req_cached <= cache_on;
        end
    end

    assign load_hit = req_load && req_cached && hit;

    ////////////////////
    // FSM
    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (req) state_next = LOOKUP;
            LOOKUP:  state_next = load_hit ? RESPOND : MEM_REQ;
            MEM_REQ: if (mem_ack) state_next = req_store ? IDLE : FILL;
            FILL:    if (fill.line_done) state_next = RESPOND;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    // Way for the fill is fixed before the pointer can move
    always_ff @(posedge clk) begin
        if (state == LOOKUP)
            fill_way <= victim_way;
    end

    always_ff @(posedge clk) begin
        if (rst)
            from_bank <= 1'b0;
        else if (state == LOOKUP)
            from_bank <= load_hit;
    end

    ////////////////////
    // Data bank and tag control
    assign lookup_en = (state == LOOKUP);
    assign lookup_way = hit_way;
    // Stores update a cached copy even while bypassing
    assign lookup_be = (req_store && hit) ? req_be : 4'b0000;
    assign fill_en = (state == FILL) && req_cached;
    assign tag_update = fill_en && fill.line_done;
    assign burst_start = (state == LOOKUP) && !load_hit;

    ////////////////////
    // Memory request
    assign mem_req = (state == MEM_REQ);
    assign mem_rnw = !req_store;
    assign mem_be = req_store ? req_be : 4'b1111;
    assign mem_wdata = req_wdata;

    always_comb begin
        if (req_load && req_cached) begin
            mem_addr = {req_addr[31:SET_LSB], {SET_LSB{1'b0}}};
            mem_burst_len = 3'(LINE_WORDS);
        end else begin
            mem_addr = {req_addr[31:WORD_LSB], {WORD_LSB{1'b0}}};
            mem_burst_len = 3'd1;
        end
    end

    ////////////////////
    // Core response
    always_ff @(posedge clk) begin
        if (state == FILL && fill.target_hit)
            miss_word <= mem_rdata;
    end

    assign ready = (state == IDLE);
    assign rvalid = (state == RESPOND);
    assign rdata = from_bank ? bank_word : miss_word;

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
// Geometry is fixed at 2 ways x 16 sets x 4 words; address fields assume 32-bit byte addresses
`default_nettype none

package dcache_pkg;

    ////////////////////
    // Cache geometry
    localparam int LINE_WORDS = 4;
    localparam int WORD_IDX_W = 2;
    localparam int SETS = 16;
    localparam int SET_IDX_W = 4;
    localparam int WAYS = 2;

    ////////////////////
    // Address fields
    // Byte offset [1:0], word [3:2], set [7:4], tag [31:8]
    localparam int WORD_LSB = 2;
    localparam int SET_LSB = WORD_LSB + WORD_IDX_W;
    localparam int TAG_LSB = SET_LSB + SET_IDX_W;
    localparam int TAG_W = 32 - TAG_LSB;

    // Data RAM word address is {way, set, word}
    localparam int BANK_ADDR_W = $clog2(WAYS) + SET_IDX_W + WORD_IDX_W;

    ////////////////////
    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_REQ,
        FILL,
        RESPOND
    } dcache_state_t;

endpackage

`default_nettype wire

//--- logic/dcache_top.sv
// Two-way write-through data cache, no write-allocate; a single outstanding request at a time
`default_nettype none
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
    (
        input  logic        clk,
        input  logic        rst,
        input  logic        cache_on,
        input  logic        req,
        input  logic        load,
        input  logic        store,
        input  logic [31:0] addr,
        input  logic [3:0]  be,
        input  logic [31:0] wdata,
        output logic        ready,
        output logic        rvalid,
        output logic [31:0] rdata,
        output logic        mem_req,
        input  logic        mem_ack,
        output logic [31:0] mem_addr,
        output logic        mem_rnw,
        output logic [3:0]  mem_be,
        output logic [31:0] mem_wdata,
        output logic [2:0]  mem_burst_len,
        input  logic        mem_rvalid,
        input  logic [31:0] mem_rdata
    );

    logic        hit;
    logic        hit_way;
    logic        victim_way;
    logic        tag_update;
    logic [31:0] bank_word;
    logic        lookup_en;
    logic        lookup_way;
    logic [3:0]  lookup_be;
    logic        fill_en;
    logic        fill_way;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic        burst_start;

    fill_if fill_bus ();

    dcache_ctrl ctrl (
        .clk           (clk),
        .rst           (rst),
        .cache_on      (cache_on),
        .req           (req),
        .load          (load),
        .store         (store),
        .addr          (addr),
        .be            (be),
        .wdata         (wdata),
        .ready         (ready),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .mem_req       (mem_req),
        .mem_ack       (mem_ack),
        .mem_addr      (mem_addr),
        .mem_rnw       (mem_rnw),
        .mem_be        (mem_be),
        .mem_wdata     (mem_wdata),
        .mem_burst_len (mem_burst_len),
        .mem_rdata     (mem_rdata),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .tag_update    (tag_update),
        .bank_word     (bank_word),
        .lookup_en     (lookup_en),
        .lookup_way    (lookup_way),
        .lookup_be     (lookup_be),
        .fill_en       (fill_en),
        .fill_way      (fill_way),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .burst_start   (burst_start),
        .fill          (fill_bus.ctrl)
    );

    fill_counter counter (
        .clk         (clk),
        .rst         (rst),
        .burst_start (burst_start),
        .mem_rvalid  (mem_rvalid),
        .req_word    (req_addr[WORD_LSB +: WORD_IDX_W]),
        .burst_len   (mem_burst_len),
        .fill        (fill_bus.counter)
    );

    // Tags are read on the acceptance edge
    dtag_bank tag_bank (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (addr),
        .req_addr    (req_addr),
        .lookup      (req && ready),
        .update      (tag_update),
        .update_way  (fill_way),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    ddata_bank data_bank (
        .clk        (clk),
        .lookup_en  (lookup_en),
        .lookup_way (lookup_way),
        .req_addr   (req_addr),
        .lookup_be  (lookup_be),
        .wdata      (req_wdata),
        .rdata      (bank_word),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .fill_data  (mem_rdata),
        .fill       (fill_bus.bank)
    );

endmodule

`default_nettype wire

//--- logic/ddata_bank.sv
// Lookup and fill ports are never active in the same cycle; read data holds until the next lookup
`default_nettype none
`timescale 1ns/1ps

module ddata_bank
    import dcache_pkg::*;
    (
        input  logic        clk,
        input  logic        lookup_en,
        input  logic        lookup_way,
        input  logic [31:0] req_addr,
        input  logic [3:0]  lookup_be,
        input  logic [31:0] wdata,
        output logic [31:0] rdata,
        input  logic        fill_en,
        input  logic        fill_way,
        input  logic [31:0] fill_data,
        fill_if.bank        fill
    );

    logic [31:0] ram [SETS * WAYS * LINE_WORDS];

    logic [BANK_ADDR_W-1:0] addr_a;
    logic [BANK_ADDR_W-1:0] addr_b;

    // {way, set, word}
    assign addr_a = {lookup_way, req_addr[WORD_LSB +: SET_IDX_W + WORD_IDX_W]};
    assign addr_b = {fill_way, req_addr[SET_LSB +: SET_IDX_W], fill.word_idx};

    always_ff @(posedge clk) begin
        // Port A writes store hit bytes or does a registered read
        if (lookup_en) begin
            for (int i = 0; i < 4; i++) begin
                if (lookup_be[i])
                    ram[addr_a][8*i +: 8] <= wdata[8*i +: 8];
            end
            rdata <= ram[addr_a];
        end
        // Port B writes line fill words from the burst
        if (fill_en && fill.word_valid)
            ram[addr_b] <= fill_data;
    end

endmodule

`default_nettype wire

//--- logic/dtag_bank.sv
// Tags are read on acceptance and compared in the next cycle; one global victim pointer for all sets
`default_nettype none
`timescale 1ns/1ps

module dtag_bank
    import dcache_pkg::*;
    (
        input  logic        clk,
        input  logic        rst,
        input  logic [31:0] lookup_addr,
        input  logic [31:0] req_addr,
        input  logic        lookup,
        input  logic        update,
        input  logic        update_way,
        output logic        hit,
        output logic        hit_way,
        output logic        victim_way
    );

    logic [TAG_W-1:0] tags [WAYS][SETS];
    logic [SETS-1:0]  valid [WAYS];

    logic [TAG_W-1:0] tag_q [WAYS];
    logic [WAYS-1:0]  valid_q;
    logic [WAYS-1:0]  way_hit;

    logic [SET_IDX_W-1:0] lookup_set;
    logic [SET_IDX_W-1:0] req_set;
    logic [TAG_W-1:0]     req_tag;

    assign lookup_set = lookup_addr[SET_LSB +: SET_IDX_W];
    assign req_set = req_addr[SET_LSB +: SET_IDX_W];
    assign req_tag = req_addr[TAG_LSB +: TAG_W];

    ////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (update)
            tags[update_way][req_set] <= req_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++)
                valid[w] <= '0;
        end else if (update) begin
            valid[update_way][req_set] <= 1'b1;
        end
    end

    ////////////////////
    // Registered read of both ways
    always_ff @(posedge clk) begin
        if (lookup) begin
            for (int w = 0; w < WAYS; w++)
                tag_q[w] <= tags[w][lookup_set];
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= '0;
        else if (lookup) begin
            for (int w = 0; w < WAYS; w++)
                valid_q[w] <= valid[w][lookup_set];
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++)
            way_hit[w] = valid_q[w] && (tag_q[w] == req_tag);
    end

    assign hit = |way_hit;
    assign hit_way = way_hit[1];

    // Toggles once per line fill
    always_ff @(posedge clk) begin
        if (rst)
            victim_way <= 1'b0;
        else if (update)
            victim_way <= ~victim_way;
    end

endmodule

`default_nettype wire

//--- logic/fill_counter.sv
// Expects burst_start before the first mem_rvalid of a burst; burst_len is 1 or LINE_WORDS
`default_nettype none
`timescale 1ns/1ps

module fill_counter
    import dcache_pkg::*;
    (
        input  logic                  clk,
        input  logic                  rst,
        input  logic                  burst_start,
        input  logic                  mem_rvalid,
        input  logic [WORD_IDX_W-1:0] req_word,
        input  logic [2:0]            burst_len,
        fill_if.counter               fill
    );

    logic [WORD_IDX_W-1:0] word_idx;
    logic [2:0]            word_count;

    // Single-word bypass reads start at the requested word
    always_ff @(posedge clk) begin
        if (rst) begin
            word_idx <= '0;
            word_count <= '0;
        end else if (burst_start) begin
            word_idx <= (burst_len == 3'd1) ? req_word : '0;
            word_count <= '0;
        end else if (mem_rvalid) begin
            word_idx <= word_idx + 1'b1;
            word_count <= word_count + 3'd1;
        end
    end

    assign fill.word_valid = mem_rvalid;
    assign fill.word_idx = word_idx;
    assign fill.target_hit = mem_rvalid && (word_idx == req_word);
    assign fill.line_done = mem_rvalid && (word_count == burst_len - 3'd1);

endmodule

`default_nettype wire

//--- logic/fill_if.sv
// Fill progress is valid only while a read burst is outstanding; all fields come from fill_counter
`default_nettype none
`timescale 1ns/1ps

interface fill_if
    import dcache_pkg::*;
    ();

    // Word arriving from memory this cycle
    logic                  word_valid;
    logic [WORD_IDX_W-1:0] word_idx;

    // Qualified with word_valid
    logic                  target_hit;
    logic                  line_done;

    modport counter (
        output word_valid,
        output word_idx,
        output target_hit,
        output line_done
    );

    modport ctrl (
        input target_hit,
        input line_done
    );

    modport bank (
        input word_valid,
        input word_idx
    );

endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f tb.f --top-module tb_dcache -Mdir obj_dir -o tb_dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_dcache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

//--- sim/tb_clkgen.sv
// Free-running clock that starts low at time zero; PERIOD_NS must be even
`default_nettype none
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- sim/tb_dcache.sv
// Random loads and stores from a fixed seed; all addresses stay below 0x300 inside the memory model
`default_nettype none
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
    ();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int DIRECTED_OPS = 16;
    localparam int RANDOM_OPS = 400;
    localparam int CYCLES_PER_OP = 100;
    localparam int WAIT_LIMIT = 200;
    localparam int WATCHDOG_NS =
        (RESET_CYCLES + DIRECTED_OPS + RANDOM_OPS) * CYCLES_PER_OP * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'hcdb0_704b;
    localparam int MEM_WORDS = 256;

    typedef struct packed {
        logic [31:0] addr;
        logic        rnw;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic [2:0]  len;
    } mem_op_t;

    logic        clk;
    logic        rst = 1'b1;
    logic        cache_on = 1'b1;
    logic        req = 1'b0;
    logic        load = 1'b0;
    logic        store = 1'b0;
    logic [31:0] addr = 32'd0;
    logic [3:0]  be = 4'd0;
    logic [31:0] wdata = 32'd0;
    logic        ready;
    logic        rvalid;
    logic [31:0] rdata;
    logic        mem_req;
    logic        mem_ack;
    logic [31:0] mem_addr;
    logic        mem_rnw;
    logic [3:0]  mem_be;
    logic [31:0] mem_wdata;
    logic [2:0]  mem_burst_len;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;

    // Reference model
    logic [31:0]      shadow [MEM_WORDS];
    logic [TAG_W-1:0] model_tag [WAYS][SETS];
    logic             model_valid [WAYS][SETS];
    logic             model_victim;
    logic [31:0]      rng_state;
    mem_op_t          mem_log [$];

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD)) clock_gen (.clk(clk));

    tb_mem #(.SEED(SEED)) mem_model (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_ack(mem_ack),
        .mem_addr(mem_addr), .mem_rnw(mem_rnw), .mem_be(mem_be),
        .mem_wdata(mem_wdata), .mem_burst_len(mem_burst_len),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
    );

    dcache_top UUT (
        .clk(clk), .rst(rst), .cache_on(cache_on), .req(req), .load(load),
        .store(store), .addr(addr), .be(be), .wdata(wdata), .ready(ready),
        .rvalid(rvalid), .rdata(rdata), .mem_req(mem_req), .mem_ack(mem_ack),
        .mem_addr(mem_addr), .mem_rnw(mem_rnw), .mem_be(mem_be),
        .mem_wdata(mem_wdata), .mem_burst_len(mem_burst_len),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
    );

    // Every memory handshake, in order
    always @(posedge clk) begin
        if (!rst && mem_req && mem_ack)
            mem_log.push_back({mem_addr, mem_rnw, mem_be, mem_wdata, mem_burst_len});
    end

    ////////////////////
    // Helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Tags 0 to 2 over four sets
    function automatic logic [31:0] pool_addr(input logic [1:0] tag_sel, input logic [1:0] set_sel,
                                              input logic [1:0] word, input logic [1:0] off);
        logic [3:0] set;
        case (set_sel)
            2'd0: set = 4'd1;
            2'd1: set = 4'd6;
            2'd2: set = 4'd11;
            default: set = 4'd15;
        endcase
        return {22'd0, tag_sel, set, word, off};
    endfunction

    function automatic logic model_hit(input logic [TAG_W-1:0] tag, input logic [3:0] set);
        logic found;
        found = 1'b0;
        for (int w = 0; w < WAYS; w++)
            if (model_valid[w][set] && model_tag[w][set] == tag)
                found = 1'b1;
        return found;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                $time, what, got, expected));
    endtask

    task automatic advance_cycle(inout int edges);
        @(posedge clk);
        edges++;
        if (edges > WAIT_LIMIT)
            abort_run("The DUT did not answer within the wait limit");
    endtask

    task automatic check_request(input logic [31:0] a, input logic rnw, input logic [3:0] b,
                                 input logic [31:0] d, input logic [2:0] len);
        mem_op_t op;
        check_value("memory request count", 32'(mem_log.size()), 32'd1);
        op = mem_log[0];
        check_value("mem_addr", op.addr, a);
        check_value("mem_rnw", 32'(op.rnw), 32'(rnw));
        check_value("mem_burst_len", 32'(op.len), 32'(len));
        if (!rnw) begin
            check_value("mem_be", 32'(op.be), 32'(b));
            check_value("mem_wdata", op.wdata, d);
        end
    endtask

    ////////////////////
    // One core request checked against the model
    task automatic run_op(input logic is_store, input logic cached, input logic [31:0] a,
                          input logic [3:0] b, input logic [31:0] d, output logic was_hit);
        logic [TAG_W-1:0] tag;
        logic [3:0]       set;
        logic [7:0]       idx;
        int               edges;
        tag = a[31:8];
        set = a[7:4];
        idx = a[9:2];
        was_hit = model_hit(tag, set);
        edges = 0;
        @(posedge clk);
        while (!ready) begin
            advance_cycle(edges);
        end
        cache_on <= cached;
        req <= 1'b1;
        load <= !is_store;
        store <= is_store;
        addr <= a;
        be <= b;
        wdata <= d;
        // Acceptance edge
        @(posedge clk);
        req <= 1'b0;
        edges = 0;
        if (is_store) begin
            do begin
                advance_cycle(edges);
                check_value("rvalid during store", 32'(rvalid), 32'd0);
            end while (!ready);
            for (int i = 0; i < 4; i++)
                if (b[i])
                    shadow[idx][8*i +: 8] = d[8*i +: 8];
            check_request({a[31:2], 2'b00}, 1'b0, b, d, 3'd1);
        end else begin
            do begin
                advance_cycle(edges);
            end while (!rvalid);
            check_value("load rdata", rdata, shadow[idx]);
            if (cached && was_hit) begin
                check_value("edges from acceptance to rvalid", 32'(edges), 32'd2);
                check_value("memory requests on hit", 32'(mem_log.size()), 32'd0);
            end else if (cached) begin
                check_request({a[31:4], 4'b0000}, 1'b1, 4'hf, 32'd0, 3'(LINE_WORDS));
                model_tag[model_victim][set] = tag;
                model_valid[model_victim][set] = 1'b1;
                model_victim = !model_victim;
            end else begin
                check_request({a[31:2], 2'b00}, 1'b1, 4'hf, 32'd0, 3'd1);
            end
            @(posedge clk);
            check_value("rvalid after one cycle", 32'(rvalid), 32'd0);
            check_value("ready after rvalid", 32'(ready), 32'd1);
        end
        mem_log.delete();
    endtask

    ////////////////////
    // Stimulus
    initial begin
        logic        hit_flag;
        logic [31:0] r;
        logic [31:0] d;
        logic [3:0]  b;
        logic [7:0]  tag_pick;
        rng_state = SEED;
        model_victim = 1'b0;
        for (int w = 0; w < WAYS; w++)
            for (int s = 0; s < SETS; s++) begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s] = '0;
            end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = mem_model.words[i];

        // Three tags into one set so the third evicts the pointer's way
        run_op(1'b0, 1'b1, pool_addr(2'd0, 2'd0, 2'd1, 2'd0), 4'h0, 32'd0, hit_flag);
        run_op(1'b0, 1'b1, pool_addr(2'd1, 2'd0, 2'd2, 2'd0), 4'h0, 32'd0, hit_flag);
        run_op(1'b0, 1'b1, pool_addr(2'd2, 2'd0, 2'd3, 2'd0), 4'h0, 32'd0, hit_flag);
        check_value("third tag predicted miss", 32'(hit_flag), 32'd0);
        run_op(1'b0, 1'b1, pool_addr(2'd1, 2'd0, 2'd0, 2'd0), 4'h0, 32'd0, hit_flag);
        check_value("kept line predicted hit", 32'(hit_flag), 32'd1);

        // Store hit, store miss, then read both back
        run_op(1'b1, 1'b1, pool_addr(2'd1, 2'd0, 2'd0, 2'd0), 4'b0101, 32'h1122_3344, hit_flag);
        run_op(1'b1, 1'b1, pool_addr(2'd0, 2'd0, 2'd2, 2'd0), 4'b1000, 32'haabb_ccdd, hit_flag);
        run_op(1'b0, 1'b1, pool_addr(2'd1, 2'd0, 2'd0, 2'd0), 4'h0, 32'd0, hit_flag);
        check_value("merged word predicted hit", 32'(hit_flag), 32'd1);
        run_op(1'b0, 1'b1, pool_addr(2'd0, 2'd0, 2'd1, 2'd0), 4'h0, 32'd0, hit_flag);
        check_value("evicted line predicted miss", 32'(hit_flag), 32'd0);
        run_op(1'b0, 1'b1, pool_addr(2'd0, 2'd0, 2'd2, 2'd0), 4'h0, 32'd0, hit_flag);

        // Bypass loads fill nothing
        run_op(1'b0, 1'b0, pool_addr(2'd2, 2'd0, 2'd3, 2'd0), 4'h0, 32'd0, hit_flag);
        run_op(1'b0, 1'b0, pool_addr(2'd1, 2'd1, 2'd1, 2'd2), 4'h0, 32'd0, hit_flag);
        run_op(1'b0, 1'b1, pool_addr(2'd2, 2'd0, 2'd3, 2'd0), 4'h0, 32'd0, hit_flag);
        check_value("line kept across bypass", 32'(hit_flag), 32'd1);
        run_op(1'b0, 1'b1, pool_addr(2'd1, 2'd1, 2'd1, 2'd2), 4'h0, 32'd0, hit_flag);
        check_value("bypass left no line", 32'(hit_flag), 32'd0);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = next_random();
            d = next_random();
            b = (r[25:22] == 4'd0) ? 4'hf : r[25:22];
            tag_pick = r[15:8] % 8'd3;
            run_op(r[2:0] < 3'd3, r[6:4] != 3'd0,
                   pool_addr(tag_pick[1:0], r[17:16], r[19:18], r[21:20]), b, d, hit_flag);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the watchdog ran out before all operations finished");
    end

endmodule

`default_nettype wire

//--- sim/tb_mem.sv
// One request at a time; only byte addresses below 0x400 are backed and higher bits are ignored
`default_nettype none
`timescale 1ns/1ps

module tb_mem #(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    output logic        mem_ack,
    input  logic [31:0] mem_addr,
    input  logic        mem_rnw,
    input  logic [3:0]  mem_be,
    input  logic [31:0] mem_wdata,
    input  logic [2:0]  mem_burst_len,
    output logic        mem_rvalid,
    output logic [31:0] mem_rdata
);

    localparam int MEM_WORDS = 256;

    logic [31:0] words [MEM_WORDS];
    logic [31:0] rng;
    logic        pending;
    logic [2:0]  wait_cnt;
    logic [7:0]  burst_ptr;
    logic [2:0]  burst_left;
    logic        ack_q = 1'b0;
    logic        rvalid_q = 1'b0;
    logic [31:0] rdata_q = 32'd0;

    assign mem_ack = ack_q;
    assign mem_rvalid = rvalid_q;
    assign mem_rdata = rdata_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            // Every word depends on its whole index
            for (int i = 0; i < MEM_WORDS; i++)
                words[i] <= (32'(i) * 32'h9e37_79b9) ^ 32'h5a17_c3e1;
            rng <= SEED;
            ack_q <= 1'b0;
            rvalid_q <= 1'b0;
            rdata_q <= 32'd0;
            pending <= 1'b0;
            wait_cnt <= 3'd0;
            burst_ptr <= 8'd0;
            burst_left <= 3'd0;
        end else begin
            rng <= xorshift32(rng);
            ack_q <= 1'b0;
            rvalid_q <= 1'b0;
            if (mem_req && ack_q) begin
                // Read data starts one cycle after the handshake edge at the earliest
                pending <= 1'b0;
                if (mem_rnw) begin
                    burst_ptr <= mem_addr[9:2];
                    burst_left <= mem_burst_len;
                end else begin
                    for (int i = 0; i < 4; i++)
                        if (mem_be[i])
                            words[mem_addr[9:2]][8*i +: 8] <= mem_wdata[8*i +: 8];
                end
            end else if (mem_req && !pending) begin
                pending <= 1'b1;
                wait_cnt <= rng[2:0];
            end else if (mem_req) begin
                if (wait_cnt == 3'd0)
                    ack_q <= 1'b1;
                else
                    wait_cnt <= wait_cnt - 3'd1;
            end else if (burst_left != 3'd0 && rng[5:4] != 2'b00) begin
                // Random gaps between burst words
                rvalid_q <= 1'b1;
                rdata_q <= words[burst_ptr];
                burst_ptr <= burst_ptr + 8'd1;
                burst_left <= burst_left - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb.f
logic/dcache_pkg.sv
logic/fill_if.sv
logic/fill_counter.sv
logic/dtag_bank.sv
logic/ddata_bank.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/tb_clkgen.sv
sim/tb_mem.sv
sim/tb_dcache.sv
